/* hw/ctrlPkg.sv */
package ctrlPkg;

	typedef logic [4:0] regIdx_t;
	typedef logic [3:0] aluOp_t;
	typedef logic [8:0] ramAddr_t;
	typedef logic [1:0] ramSize_t;
	typedef logic [1:0] srcSel_t; // ALU B-input mux
	typedef logic [3:0] cmpSel_t;

	typedef struct packed {
		logic [5:0] opcode;
		regIdx_t    rs;
		regIdx_t    rt;
		regIdx_t    rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		regIdx_t     rs;
		regIdx_t     rt;
		logic [15:0] imm;
	} iFields_t;

	// Same 32 bits, seen as R-type or I-type
	typedef union packed {
		rFields_t rType;
		iFields_t iType;
	} instrWord_t;

	typedef enum logic [3:0] {
		stReset,
		stFetchAddr,
		stFetchIssue,
		stFetchWait,
		stFetchLoad,
		stDecode,
		stExec,
		stExecTrap,  // Overflow check cycle, no write
		stCommit,
		stTrap,
		stMemAddr,
		stLoadWait,
		stMdrLoad,
		stLoadWrite,
		stStoreData,
		stStoreWait
	} ctrlState_t;

	typedef enum logic [2:0] {
		opAlu,
		opAluTrap,
		opLoad,
		opStore,
		opInvalid
	} opClass_t;

	localparam logic [5:0] opcSpecial = 6'b000000;
	localparam logic [5:0] opcAddi    = 6'b001000;
	localparam logic [5:0] opcAddiu   = 6'b001001;
	localparam logic [5:0] opcSlti    = 6'b001010;
	localparam logic [5:0] opcSltiu   = 6'b001011;
	localparam logic [5:0] opcAndi    = 6'b001100;
	localparam logic [5:0] opcOri     = 6'b001101;
	localparam logic [5:0] opcXori    = 6'b001110;
	localparam logic [5:0] opcLui     = 6'b001111;
	localparam logic [5:0] opcLb      = 6'b100000;
	localparam logic [5:0] opcLh      = 6'b100001;
	localparam logic [5:0] opcLw      = 6'b100011;
	localparam logic [5:0] opcLbu     = 6'b100100;
	localparam logic [5:0] opcLhu     = 6'b100101;
	localparam logic [5:0] opcSb      = 6'b101000;
	localparam logic [5:0] opcSh      = 6'b101001;
	localparam logic [5:0] opcSw      = 6'b101011;

	localparam logic [5:0] fnSllv = 6'b000100;
	localparam logic [5:0] fnSrlv = 6'b000110;
	localparam logic [5:0] fnSrav = 6'b000111;
	localparam logic [5:0] fnAdd  = 6'b100000;
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSub  = 6'b100010;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd  = 6'b100100;
	localparam logic [5:0] fnOr   = 6'b100101;
	localparam logic [5:0] fnXor  = 6'b100110;
	localparam logic [5:0] fnNor  = 6'b100111;
	localparam logic [5:0] fnSlt  = 6'b101010;
	localparam logic [5:0] fnSltu = 6'b101011;

	localparam aluOp_t aluPass    = 4'b0000;
	localparam aluOp_t aluAdd     = 4'b0001; // Add or sub, aluSign decides
	localparam aluOp_t aluAnd     = 4'b0100;
	localparam aluOp_t aluOr      = 4'b0101;
	localparam aluOp_t aluNor     = 4'b0110;
	localparam aluOp_t aluSrl     = 4'b0111;
	localparam aluOp_t aluSll     = 4'b1000;
	localparam aluOp_t aluSra     = 4'b1001;
	localparam aluOp_t aluLui     = 4'b1010;
	localparam aluOp_t aluIncPc   = 4'b1011;
	localparam aluOp_t aluXor     = 4'b1100;
	localparam aluOp_t aluCompare = 4'b1101;

	localparam logic [1:0] signUnsAdd = 2'b00;
	localparam logic [1:0] signUnsSub = 2'b01;
	localparam logic [1:0] signAdd    = 2'b10; // Signed ops raise overflow
	localparam logic [1:0] signSub    = 2'b11;

	localparam cmpSel_t cmpSlt   = 4'b0000;
	localparam cmpSel_t cmpSltu  = 4'b0001;
	localparam cmpSel_t cmpSlti  = 4'b0010;
	localparam cmpSel_t cmpSltiu = 4'b0011;

	localparam ramSize_t sizeByte = 2'b00;
	localparam ramSize_t sizeHalf = 2'b01;
	localparam ramSize_t sizeWord = 2'b11;

	localparam srcSel_t srcReg = 2'b00;
	localparam srcSel_t srcImm = 2'b01;
	localparam srcSel_t srcMdr = 2'b10;
	localparam srcSel_t srcPc  = 2'b11;

	localparam ramAddr_t trapVector = 9'd448; // Overflow handler

endpackage

/* hw/instrDecoder.sv */
`timescale 1ns/10ps

module instrDecoder (
	input  ctrlPkg::instrWord_t instruction,
	output ctrlPkg::opClass_t   opClass,
	output ctrlPkg::aluOp_t     aluOp,
	output logic [1:0]          aluSign,
	output ctrlPkg::cmpSel_t    cmpSel,
	output logic                useImm,
	output logic                signExt,
	output ctrlPkg::ramSize_t   ramSize,
	output ctrlPkg::regIdx_t    destIdx,
	output ctrlPkg::regIdx_t    srcIdx,
	output ctrlPkg::regIdx_t    tgtIdx
);

	import ctrlPkg::*;

	always_comb begin
		// I-type defaults, R-type overrides below
		opClass = opInvalid;
		aluOp   = aluPass;
		aluSign = signUnsAdd;
		cmpSel  = cmpSlt;
		useImm  = 1'b1;
		signExt = 1'b1;
		ramSize = sizeWord;
		srcIdx  = instruction.iType.rs;
		tgtIdx  = instruction.iType.rt;
		destIdx = instruction.iType.rt;

		if (instruction.rType.opcode == opcSpecial) begin
			useImm  = 1'b0;
			srcIdx  = instruction.rType.rs;
			tgtIdx  = instruction.rType.rt;
			destIdx = instruction.rType.rd;
			opClass = opAlu;
			case (instruction.rType.funct)
				fnAdd: begin
					aluOp   = aluAdd;
					aluSign = signAdd;
					opClass = opAluTrap;
				end
				fnSub: begin
					aluOp   = aluAdd;
					aluSign = signSub;
					opClass = opAluTrap;
				end
				fnAddu: aluOp = aluAdd;
				fnSubu: begin
					aluOp   = aluAdd;
					aluSign = signUnsSub;
				end
				fnAnd:  aluOp = aluAnd;
				fnOr:   aluOp = aluOr;
				fnXor:  aluOp = aluXor;
				fnNor:  aluOp = aluNor;
				fnSllv: aluOp = aluSll;
				fnSrlv: aluOp = aluSrl;
				fnSrav: aluOp = aluSra;
				fnSlt:  aluOp = aluCompare;
				fnSltu: begin
					aluOp  = aluCompare;
					cmpSel = cmpSltu;
				end
				default: opClass = opInvalid; // Unsupported funct
			endcase
		end else begin
			opClass = opAlu;
			aluOp   = aluAdd; // Address calc for loads and stores
			case (instruction.iType.opcode)
				opcAddi: begin
					aluSign = signAdd;
					opClass = opAluTrap;
				end
				opcAddiu: aluSign = signUnsAdd; // Wraps, never traps
				opcAndi: begin
					aluOp   = aluAnd;
					signExt = 1'b0;
				end
				opcOri: begin
					aluOp   = aluOr;
					signExt = 1'b0;
				end
				opcXori: begin
					aluOp   = aluXor;
					signExt = 1'b0;
				end
				opcLui: begin
					aluOp   = aluLui;
					signExt = 1'b0;
				end
				opcSlti: begin
					aluOp  = aluCompare;
					cmpSel = cmpSlti;
				end
				opcSltiu: begin
					aluOp  = aluCompare;
					cmpSel = cmpSltiu;
				end
				opcLw:  opClass = opLoad;
				opcLh: begin
					opClass = opLoad;
					ramSize = sizeHalf;
				end
				opcLhu: begin
					opClass = opLoad;
					ramSize = sizeHalf;
					signExt = 1'b0;
				end
				opcLb: begin
					opClass = opLoad;
					ramSize = sizeByte;
				end
				opcLbu: begin
					opClass = opLoad;
					ramSize = sizeByte;
					signExt = 1'b0;
				end
				opcSw:  opClass = opStore;
				opcSh: begin
					opClass = opStore;
					ramSize = sizeHalf;
				end
				opcSb: begin
					opClass = opStore;
					ramSize = sizeByte;
				end
				default: begin
					opClass = opInvalid;
					aluOp   = aluPass;
				end
			endcase
		end
	end

endmodule

/* hw/controlSequencer.sv */
`timescale 1ns/10ps

module controlSequencer (
	input  logic                Clk,
	input  logic                reset,
	input  ctrlPkg::opClass_t   opClass,
	input  logic                ramMFC,
	input  logic [3:0]          aluCarryFlags, // Bit 0 is overflow
	output ctrlPkg::ctrlState_t state
);

	import ctrlPkg::*;

	ctrlState_t nextState;

	always_ff @(posedge Clk) begin
		if (reset) begin
			state <= stReset;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			stReset:     nextState = stFetchAddr;
			stFetchAddr: nextState = stFetchIssue;

			// Request goes out here, memory may answer at once
			stFetchIssue: begin
				if (ramMFC) begin
					nextState = stFetchLoad;
				end else begin
					nextState = stFetchWait;
				end
			end
			stFetchWait: begin
				if (ramMFC) begin
					nextState = stFetchLoad;
				end
			end
			stFetchLoad: nextState = stDecode;

			stDecode: begin
				case (opClass)
					opAlu:           nextState = stExec;
					opAluTrap:       nextState = stExecTrap;
					opLoad, opStore: nextState = stMemAddr;
					default:         nextState = stFetchAddr; // Skip unknown opcode
				endcase
			end

			stExec: nextState = stFetchAddr;
			stExecTrap: begin
				if (aluCarryFlags[0]) begin
					nextState = stTrap;
				end else begin
					nextState = stCommit;
				end
			end
			stCommit: nextState = stFetchAddr;

			// Handler word is fetched straight into the IR
			stTrap: begin
				if (ramMFC) begin
					nextState = stFetchLoad;
				end
			end

			stMemAddr: begin
				if (opClass == opStore) begin
					nextState = stStoreData;
				end else begin
					nextState = stLoadWait;
				end
			end
			stLoadWait: begin
				if (ramMFC) begin
					nextState = stMdrLoad;
				end
			end
			stMdrLoad:   nextState = stLoadWrite;
			stLoadWrite: nextState = stFetchAddr;
			stStoreData: nextState = stStoreWait;
			stStoreWait: begin
				if (ramMFC) begin
					nextState = stFetchAddr;
				end
			end
			default: nextState = stReset;
		endcase
	end

endmodule

/* hw/datapathControl.sv */
`timescale 1ns/10ps

module datapathControl (
	input  ctrlPkg::ctrlState_t state,
	input  ctrlPkg::aluOp_t     aluOp,
	input  logic [1:0]          decSign,
	input  ctrlPkg::cmpSel_t    cmpSel,
	input  logic                useImm,
	input  logic                signExt,
	input  ctrlPkg::ramSize_t   ramSize,
	input  ctrlPkg::regIdx_t    destIdx,
	input  ctrlPkg::regIdx_t    srcIdx,
	input  ctrlPkg::regIdx_t    tgtIdx,
	output logic                trapMux,
	output logic                signExtend,
	output logic                clearPC,
	output logic                regFileRW,
	output ctrlPkg::regIdx_t    regFileRD,
	output ctrlPkg::regIdx_t    regFileRS,
	output ctrlPkg::regIdx_t    regFileRT,
	output logic [1:0]          aluSign,
	output ctrlPkg::aluOp_t     aluOperation,
	output ctrlPkg::cmpSel_t    cmpsignal,
	output ctrlPkg::ramSize_t   ramDataSize,
	output logic                ramMFA,
	output logic                ramRW,
	output ctrlPkg::ramAddr_t   ramAddress,
	output logic                pcEnable,
	output logic                irEnable,
	output logic                marEnable,
	output logic                mdrEnable,
	output ctrlPkg::srcSel_t    muxSignals,
	output logic                muxSignals2
);

	import ctrlPkg::*;

	always_comb begin
		// Idle values, each state turns on only what it needs
		trapMux      = 1'b0;
		signExtend   = signExt;
		clearPC      = 1'b0;
		regFileRW    = 1'b0;
		regFileRD    = destIdx;
		regFileRS    = srcIdx;
		regFileRT    = tgtIdx;
		aluSign      = signUnsAdd;
		aluOperation = aluPass;
		cmpsignal    = cmpSel;
		ramDataSize  = sizeWord;
		ramMFA       = 1'b0;
		ramRW        = 1'b0;
		ramAddress   = '0;
		pcEnable     = 1'b0;
		irEnable     = 1'b0;
		marEnable    = 1'b0;
		mdrEnable    = 1'b0;
		muxSignals   = srcReg;
		muxSignals2  = 1'b0;

		case (state)
			stReset: clearPC = 1'b1;
			stFetchAddr: begin
				marEnable  = 1'b1; // PC into MAR
				muxSignals = srcPc;
			end
			stFetchIssue, stFetchWait: begin
				pcEnable     = (state == stFetchIssue); // PC + 4 once
				aluOperation = aluIncPc;
				muxSignals   = srcPc;
				ramMFA       = 1'b1;
			end
			stFetchLoad: irEnable = 1'b1;

			// Commit writes what stExecTrap computed
			stExec, stExecTrap, stCommit: begin
				aluOperation = aluOp;
				aluSign      = decSign;
				muxSignals   = useImm ? srcImm : srcReg;
				regFileRW    = (state != stExecTrap);
			end
			stTrap: begin
				trapMux    = 1'b1;
				ramAddress = trapVector;
				ramMFA     = 1'b1;
			end

			stMemAddr: begin
				aluOperation = aluAdd; // Base plus offset
				muxSignals   = srcImm;
				signExtend   = 1'b1;
				marEnable    = 1'b1;
			end
			stLoadWait: begin
				ramDataSize = ramSize;
				ramMFA      = 1'b1;
			end
			stMdrLoad: begin
				mdrEnable   = 1'b1;
				muxSignals2 = 1'b1; // MDR from memory
			end
			stLoadWrite: begin
				muxSignals  = srcMdr;
				muxSignals2 = 1'b1;
				regFileRW   = 1'b1;
			end
			stStoreData: mdrEnable = 1'b1; // MDR from rt
			stStoreWait: begin
				ramDataSize = ramSize;
				ramMFA      = 1'b1;
				ramRW       = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

/* hw/controlUnit.sv */
`timescale 1ns/10ps

module controlUnit (
	input  logic                Clk,
	input  logic                reset,
	input  ctrlPkg::instrWord_t instruction,   // From the IR
	input  logic [3:0]          aluCarryFlags,
	input  logic                ramMFC,
	output logic                trapMux,
	output logic                signExtend,
	output logic                clearPC,
	output logic                regFileRW,
	output ctrlPkg::regIdx_t    regFileRD,
	output ctrlPkg::regIdx_t    regFileRS,
	output ctrlPkg::regIdx_t    regFileRT,
	output logic [1:0]          aluSign,
	output ctrlPkg::aluOp_t     aluOperation,
	output ctrlPkg::cmpSel_t    cmpsignal,
	output ctrlPkg::ramSize_t   ramDataSize,
	output logic                ramMFA,
	output logic                ramRW,
	output ctrlPkg::ramAddr_t   ramAddress,
	output logic                pcEnable,
	output logic                irEnable,
	output logic                marEnable,
	output logic                mdrEnable,
	output ctrlPkg::srcSel_t    muxSignals,    // ALU B-input
	output logic                muxSignals2    // MDR source
);

	import ctrlPkg::*;

	opClass_t   opClass;
	ctrlState_t state;
	aluOp_t     aluOp;
	logic [1:0] decSign;
	cmpSel_t    cmpSel;
	logic       useImm;
	logic       signExt;
	ramSize_t   ramSize;
	regIdx_t    destIdx;
	regIdx_t    srcIdx;
	regIdx_t    tgtIdx;

	instrDecoder decoder (
		.instruction (instruction),
		.opClass     (opClass),
		.aluOp       (aluOp),
		.aluSign     (decSign),
		.cmpSel      (cmpSel),
		.useImm      (useImm),
		.signExt     (signExt),
		.ramSize     (ramSize),
		.destIdx     (destIdx),
		.srcIdx      (srcIdx),
		.tgtIdx      (tgtIdx)
	);

	controlSequencer sequencer (
		.Clk           (Clk),
		.reset         (reset),
		.opClass       (opClass),
		.ramMFC        (ramMFC),
		.aluCarryFlags (aluCarryFlags),
		.state         (state)
	);

	datapathControl ctrlTable (
		.state        (state),
		.aluOp        (aluOp),
		.decSign      (decSign),
		.cmpSel       (cmpSel),
		.useImm       (useImm),
		.signExt      (signExt),
		.ramSize      (ramSize),
		.destIdx      (destIdx),
		.srcIdx       (srcIdx),
		.tgtIdx       (tgtIdx),
		.trapMux      (trapMux),
		.signExtend   (signExtend),
		.clearPC      (clearPC),
		.regFileRW    (regFileRW),
		.regFileRD    (regFileRD),
		.regFileRS    (regFileRS),
		.regFileRT    (regFileRT),
		.aluSign      (aluSign),
		.aluOperation (aluOperation),
		.cmpsignal    (cmpsignal),
		.ramDataSize  (ramDataSize),
		.ramMFA       (ramMFA),
		.ramRW        (ramRW),
		.ramAddress   (ramAddress),
		.pcEnable     (pcEnable),
		.irEnable     (irEnable),
		.marEnable    (marEnable),
		.mdrEnable    (mdrEnable),
		.muxSignals   (muxSignals),
		.muxSignals2  (muxSignals2)
	);

endmodule

/* test/tbControlUnit.sv */
`timescale 1ns/10ps

module tbControlUnit;

	import ctrlPkg::*;

	// DUT inputs
	logic       Clk = 1'b0;
	logic       reset = 1'b1;
	instrWord_t instruction = '0;
	logic [3:0] aluCarryFlags = 4'd0;
	logic       ramMFC = 1'b0;

	// DUT outputs
	logic       trapMux;
	logic       signExtend;
	logic       clearPC;
	logic       regFileRW;
	regIdx_t    regFileRD;
	regIdx_t    regFileRS;
	regIdx_t    regFileRT;
	logic [1:0] aluSign;
	aluOp_t     aluOperation;
	cmpSel_t    cmpsignal;
	ramSize_t   ramDataSize;
	logic       ramMFA;
	logic       ramRW;
	ramAddr_t   ramAddress;
	logic       pcEnable;
	logic       irEnable;
	logic       marEnable;
	logic       mdrEnable;
	srcSel_t    muxSignals;
	logic       muxSignals2;

	integer      seed = 94747;
	logic [31:0] progWords[$];
	int          progIdx = 0;
	int          doneCount = 0;
	int          trapsTaken = 0;
	int          trapsSkipped = 0;

	// Driver side state
	int         sinceLoad = 100;
	logic       trapFlag = 1'b0;   // Overflow chosen for the current word
	logic       startPending = 1'b0;
	logic       busy = 1'b0;
	logic [1:0] respDelay = 2'd0;

	// Monitor side state
	logic        irSeen = 1'b0;
	logic        irExpected = 1'b0;
	logic        fetchPending = 1'b0;
	logic        prevReset = 1'b1;
	logic        prevMfa = 1'b0;
	logic        prevMfc = 1'b0;
	logic        prevRW = 1'b0;
	ramSize_t    prevSize = sizeWord;
	ramAddr_t    prevAddr = '0;
	logic        winActive = 1'b0;
	logic [31:0] winWord = '0;
	opClass_t    winClass = opInvalid;
	int          writeCount = 0;
	int          reqCount = 0;
	int          stage = 0;
	logic        trapSeen = 1'b0;
	int          idleCycles = 0;

	controlUnit UUT (
		.Clk           (Clk),
		.reset         (reset),
		.instruction   (instruction),
		.aluCarryFlags (aluCarryFlags),
		.ramMFC        (ramMFC),
		.trapMux       (trapMux),
		.signExtend    (signExtend),
		.clearPC       (clearPC),
		.regFileRW     (regFileRW),
		.regFileRD     (regFileRD),
		.regFileRS     (regFileRS),
		.regFileRT     (regFileRT),
		.aluSign       (aluSign),
		.aluOperation  (aluOperation),
		.cmpsignal     (cmpsignal),
		.ramDataSize   (ramDataSize),
		.ramMFA        (ramMFA),
		.ramRW         (ramRW),
		.ramAddress    (ramAddress),
		.pcEnable      (pcEnable),
		.irEnable      (irEnable),
		.marEnable     (marEnable),
		.mdrEnable     (mdrEnable),
		.muxSignals    (muxSignals),
		.muxSignals2   (muxSignals2)
	);

	always #5 Clk = ~Clk;

	task automatic failRun(input string what);
		$display("ERROR at time %0t: %s", $time, what);
		$display("test failed");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic failValue(input string name, input logic [31:0] expVal,
			input logic [31:0] actVal);
		$display("MISMATCH at time %0t: %s expected %0h, actual %0h", $time, name, expVal,
			actVal);
		failRun("signal value mismatch");
	endtask

	task automatic expectEqual(input string name, input logic [31:0] expVal,
			input logic [31:0] actVal);
		assert (actVal == expVal) else failValue(name, expVal, actVal);
	endtask

	function automatic logic [31:0] rWord(input int rs, input int rt, input int rd,
			input logic [5:0] funct);
		rWord = {opcSpecial, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
	endfunction

	function automatic logic [31:0] iWord(input logic [5:0] opc, input int rs, input int rt,
			input logic [15:0] imm);
		iWord = {opc, rs[4:0], rt[4:0], imm};
	endfunction

	// Instruction class as the ISA subset defines it
	function automatic opClass_t expectedClass(input logic [31:0] word);
		logic [5:0] opc;
		logic [5:0] fn;
		opc = word[31:26];
		fn = word[5:0];
		expectedClass = opInvalid;
		if (opc == opcSpecial) begin
			if (fn inside {fnAdd, fnSub})
				expectedClass = opAluTrap;
			else if (fn inside {fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSllv, fnSrlv,
					fnSrav, fnSlt, fnSltu})
				expectedClass = opAlu;
		end else if (opc == opcAddi) begin
			expectedClass = opAluTrap;
		end else if (opc inside {opcAddiu, opcAndi, opcOri, opcXori, opcSlti, opcSltiu,
				opcLui}) begin
			expectedClass = opAlu;
		end else if (opc inside {opcLw, opcLh, opcLhu, opcLb, opcLbu}) begin
			expectedClass = opLoad;
		end else if (opc inside {opcSw, opcSh, opcSb}) begin
			expectedClass = opStore;
		end
	endfunction

	function automatic aluOp_t expectedAluOp(input logic [31:0] word);
		expectedAluOp = aluPass;
		if (word[31:26] == opcSpecial) begin
			case (word[5:0])
				fnAdd, fnAddu, fnSub, fnSubu: expectedAluOp = aluAdd;
				fnAnd:         expectedAluOp = aluAnd;
				fnOr:          expectedAluOp = aluOr;
				fnXor:         expectedAluOp = aluXor;
				fnNor:         expectedAluOp = aluNor;
				fnSllv:        expectedAluOp = aluSll;
				fnSrlv:        expectedAluOp = aluSrl;
				fnSrav:        expectedAluOp = aluSra;
				fnSlt, fnSltu: expectedAluOp = aluCompare;
				default:       expectedAluOp = aluPass;
			endcase
		end else begin
			case (word[31:26])
				opcAddi, opcAddiu:  expectedAluOp = aluAdd;
				opcAndi:            expectedAluOp = aluAnd;
				opcOri:             expectedAluOp = aluOr;
				opcXori:            expectedAluOp = aluXor;
				opcLui:             expectedAluOp = aluLui;
				opcSlti, opcSltiu:  expectedAluOp = aluCompare;
				default:            expectedAluOp = aluPass;
			endcase
		end
	endfunction

	function automatic logic [1:0] expectedSign(input logic [31:0] word);
		expectedSign = signUnsAdd;
		if (word[31:26] == opcAddi)
			expectedSign = signAdd;
		else if (word[31:26] == opcSpecial && word[5:0] == fnAdd)
			expectedSign = signAdd;
		else if (word[31:26] == opcSpecial && word[5:0] == fnSub)
			expectedSign = signSub;
		else if (word[31:26] == opcSpecial && word[5:0] == fnSubu)
			expectedSign = signUnsSub;
	endfunction

	function automatic cmpSel_t expectedCmp(input logic [31:0] word);
		expectedCmp = cmpSlt;
		if (word[31:26] == opcSlti)
			expectedCmp = cmpSlti;
		else if (word[31:26] == opcSltiu)
			expectedCmp = cmpSltiu;
		else if (word[31:26] == opcSpecial && word[5:0] == fnSltu)
			expectedCmp = cmpSltu;
	endfunction

	function automatic ramSize_t expectedSize(input logic [31:0] word);
		expectedSize = sizeWord;
		if (word[31:26] inside {opcLh, opcLhu, opcSh})
			expectedSize = sizeHalf;
		else if (word[31:26] inside {opcLb, opcLbu, opcSb})
			expectedSize = sizeByte;
	endfunction

	task automatic buildProgram();
		progWords.push_back(rWord(1, 2, 3, fnAdd));
		progWords.push_back(rWord(4, 5, 6, fnAddu));
		progWords.push_back(rWord(7, 8, 9, fnSub));
		progWords.push_back(rWord(10, 11, 12, fnSubu));
		progWords.push_back(rWord(13, 14, 15, fnAnd));
		progWords.push_back(rWord(16, 17, 18, fnOr));
		progWords.push_back(rWord(19, 20, 21, fnXor));
		progWords.push_back(rWord(22, 23, 24, fnNor));
		progWords.push_back(rWord(25, 26, 27, fnSllv));
		progWords.push_back(rWord(28, 29, 30, fnSrlv));
		progWords.push_back(rWord(31, 1, 2, fnSrav));
		progWords.push_back(rWord(3, 4, 5, fnSlt));
		progWords.push_back(rWord(6, 7, 8, fnSltu));
		progWords.push_back(iWord(opcAddi, 9, 10, 16'h7fff));
		progWords.push_back(iWord(opcAddiu, 11, 12, 16'h8001));
		progWords.push_back(iWord(opcAndi, 13, 14, 16'h00ff));
		progWords.push_back(iWord(opcOri, 15, 16, 16'hf0f0));
		progWords.push_back(iWord(opcXori, 17, 18, 16'h5555));
		progWords.push_back(iWord(opcSlti, 19, 20, 16'hfff0));
		progWords.push_back(iWord(opcSltiu, 21, 22, 16'h0010));
		progWords.push_back(iWord(opcLui, 0, 23, 16'h1234));
		progWords.push_back(iWord(6'b111111, 24, 25, 16'h0000)); // No such opcode
		progWords.push_back(iWord(opcLw, 29, 8, 16'h0010));
		progWords.push_back(iWord(opcLh, 29, 9, 16'h0022));
		progWords.push_back(iWord(opcLhu, 28, 10, 16'h0024));
		progWords.push_back(iWord(opcLb, 28, 11, 16'h0031));
		progWords.push_back(iWord(opcLbu, 27, 12, 16'h0033));
		progWords.push_back(iWord(opcSw, 29, 13, 16'h0040));
		progWords.push_back(iWord(opcSh, 29, 14, 16'h0046));
		progWords.push_back(iWord(opcSb, 26, 15, 16'h0047));
		// More trapping words so both overflow outcomes show up
		for (int k = 0; k < 3; k++) begin
			progWords.push_back(rWord(k + 10, k + 11, k + 12, fnAdd));
			progWords.push_back(rWord(k + 20, k + 21, k + 22, fnSub));
			progWords.push_back(iWord(opcAddi, k + 1, k + 2, 16'h4000));
		end
	endtask

	task automatic checkAluControls(input logic [31:0] word);
		expectEqual("aluOperation", 32'(expectedAluOp(word)), 32'(aluOperation));
		expectEqual("aluSign", 32'(expectedSign(word)), 32'(aluSign));
		expectEqual("cmpsignal", 32'(expectedCmp(word)), 32'(cmpsignal));
		expectEqual("regFileRS", 32'(word[25:21]), 32'(regFileRS));
		expectEqual("regFileRT", 32'(word[20:16]), 32'(regFileRT));
		if (word[31:26] inside {opcAndi, opcOri, opcXori, opcLui})
			expectEqual("signExtend", 32'd0, 32'(signExtend));
		else
			expectEqual("signExtend", 32'd1, 32'(signExtend));
		if (word[31:26] == opcSpecial) begin
			expectEqual("muxSignals", 32'(srcReg), 32'(muxSignals));
			expectEqual("regFileRD", 32'(word[15:11]), 32'(regFileRD));
		end else begin
			expectEqual("muxSignals", 32'(srcImm), 32'(muxSignals));
			expectEqual("regFileRD", 32'(word[20:16]), 32'(regFileRD));
		end
	endtask

	// Closes the window of one program word at the next fetch or trap fetch
	task automatic finishInstr();
		case (winClass)
			opAlu: expectEqual("regFileRW pulses", 32'd1, 32'(writeCount));
			opAluTrap: begin
				if (trapFlag) begin
					expectEqual("regFileRW pulses", 32'd0, 32'(writeCount));
					assert (trapSeen) else failRun("overflow flag set but no trap fetch");
					trapsTaken++;
				end else begin
					expectEqual("regFileRW pulses", 32'd1, 32'(writeCount));
					trapsSkipped++;
				end
			end
			opLoad: begin
				assert (stage == 3) else failRun("load did not finish read, MDR and write");
				expectEqual("regFileRW pulses", 32'd1, 32'(writeCount));
				expectEqual("memory requests", 32'd1, 32'(reqCount));
			end
			opStore: begin
				assert (stage == 2) else failRun("store did not finish MDR and write");
				expectEqual("regFileRW pulses", 32'd0, 32'(writeCount));
				expectEqual("memory requests", 32'd1, 32'(reqCount));
			end
			default: expectEqual("regFileRW pulses", 32'd0, 32'(writeCount));
		endcase
		winActive = 1'b0;
		doneCount++;
	endtask

	// Inputs change 1 ns after the rising edge
	always @(posedge Clk) begin
		logic [31:0] rnd;
		#1;
		rnd = $random(seed);
		aluCarryFlags = rnd[3:0]; // Only bit 0 in stExecTrap counts
		sinceLoad++;
		if (sinceLoad == 1 && expectedClass(instruction) == opAluTrap)
			trapFlag = rnd[0];

		// IR model
		if (irSeen) begin
			startPending = (progIdx < progWords.size());
			if (progIdx < progWords.size())
				instruction = progWords[progIdx];
			else
				instruction = 32'hfc00_0000; // Filler, invalid opcode
			progIdx++;
			sinceLoad = 0;
			trapFlag = 1'b0;
		end

		// Memory responder, 0 to 3 cycles of back-pressure
		if (ramMFC) begin
			ramMFC = 1'b0;
			busy = 1'b0;
		end else if (ramMFA) begin
			if (!busy) begin
				rnd = $random(seed);
				respDelay = rnd[1:0];
				busy = 1'b1;
			end
			if (respDelay == 2'd0)
				ramMFC = 1'b1;
			else
				respDelay = respDelay - 2'd1;
		end
	end

	// Checks at the falling edge, where every output is settled
	always @(negedge Clk) begin
		logic reqStart;
		logic fetchStart;
		reqStart = ramMFA && !prevMfa;
		fetchStart = marEnable && (muxSignals == srcPc);

		if (reset || prevReset) begin
			expectEqual("clearPC", 32'd1, 32'(clearPC));
			expectEqual("ramMFA", 32'd0, 32'(ramMFA));
			expectEqual("regFileRW", 32'd0, 32'(regFileRW));
			expectEqual("trapMux", 32'd0, 32'(trapMux));
			expectEqual("pcEnable", 32'd0, 32'(pcEnable));
			expectEqual("irEnable", 32'd0, 32'(irEnable));
			expectEqual("marEnable", 32'd0, 32'(marEnable));
			expectEqual("mdrEnable", 32'd0, 32'(mdrEnable));
		end

		// Handshake
		if (ramMFA && prevMfa && !prevMfc) begin
			expectEqual("ramRW", 32'(prevRW), 32'(ramRW));
			expectEqual("ramDataSize", 32'(prevSize), 32'(ramDataSize));
			expectEqual("ramAddress", 32'(prevAddr), 32'(ramAddress));
		end
		if (prevMfc)
			expectEqual("ramMFA", 32'd0, 32'(ramMFA));
		expectEqual("irEnable", 32'(irExpected), 32'(irEnable));

		if (trapMux) begin
			expectEqual("ramMFA", 32'd1, 32'(ramMFA));
			expectEqual("ramAddress", 32'(trapVector), 32'(ramAddress));
			expectEqual("ramRW", 32'd0, 32'(ramRW));
			assert (winActive && winClass == opAluTrap && trapFlag)
				else failRun("trap taken without an overflowing add, sub or addi");
			trapSeen = 1'b1;
		end

		if (winActive && (fetchStart || irEnable))
			finishInstr();

		if (startPending) begin
			startPending = 1'b0;
			winActive = 1'b1;
			winWord = instruction;
			winClass = expectedClass(instruction);
			writeCount = 0;
			reqCount = 0;
			stage = 0;
			trapSeen = 1'b0;
		end

		if (winActive) begin
			if (regFileRW) begin
				writeCount++;
				assert (winClass inside {opAlu, opAluTrap, opLoad})
					else failRun("register write during a store or invalid word");
				case (winClass)
					opAlu, opAluTrap: checkAluControls(winWord);
					opLoad: begin
						assert (stage == 2) else failRun("load write before MDR load");
						expectEqual("muxSignals", 32'(srcMdr), 32'(muxSignals));
						expectEqual("regFileRD", 32'(winWord[20:16]), 32'(regFileRD));
						stage = 3;
					end
					default: ;
				endcase
			end
			if (mdrEnable) begin
				assert (winClass inside {opLoad, opStore})
					else failRun("mdrEnable outside a load or store");
				case (winClass)
					opLoad: begin
						assert (stage == 1) else failRun("MDR load before the memory read");
						expectEqual("muxSignals2", 32'd1, 32'(muxSignals2));
						stage = 2;
					end
					opStore: begin
						assert (stage == 0) else failRun("store MDR load out of order");
						expectEqual("muxSignals2", 32'd0, 32'(muxSignals2));
						stage = 1;
					end
					default: ;
				endcase
			end
			if (reqStart && !trapMux) begin
				reqCount++;
				assert (winClass inside {opLoad, opStore})
					else failRun("memory request from an ALU or invalid word");
				case (winClass)
					opLoad: begin
						assert (stage == 0) else failRun("extra memory read in a load");
						expectEqual("ramRW", 32'd0, 32'(ramRW));
						expectEqual("ramDataSize", 32'(expectedSize(winWord)),
							32'(ramDataSize));
						stage = 1;
					end
					opStore: begin
						assert (stage == 1) else failRun("store write before MDR load");
						expectEqual("ramRW", 32'd1, 32'(ramRW));
						expectEqual("ramDataSize", 32'(expectedSize(winWord)),
							32'(ramDataSize));
						stage = 2;
					end
					default: ;
				endcase
			end
			assert (!(marEnable && winClass == opInvalid))
				else failRun("marEnable raised for an invalid opcode");
		end

		// Fetch bookkeeping for the irEnable check
		if (pcEnable || (trapMux && ramMFA))
			fetchPending = 1'b1;
		irExpected = ramMFC && fetchPending;
		if (ramMFC)
			fetchPending = 1'b0;

		if (irEnable || reset)
			idleCycles = 0;
		else
			idleCycles++;
		if (idleCycles > 60)
			failRun("timeout, no instruction fetched for 60 cycles");

		irSeen = irEnable;
		prevReset = reset;
		prevMfa = ramMFA;
		prevMfc = ramMFC;
		prevRW = ramRW;
		prevSize = ramDataSize;
		prevAddr = ramAddress;
	end

	initial begin
		int waitCycles;
		buildProgram();
		repeat (10) @(posedge Clk);
		#1 reset = 1'b0;

		waitCycles = 0;
		while (doneCount < progWords.size() && waitCycles < 2000) begin
			@(posedge Clk);
			waitCycles++;
		end

		if (doneCount < progWords.size())
			failRun("timeout, program did not complete in 2000 cycles");
		else if (trapsTaken == 0 || trapsSkipped == 0)
			failRun("overflow stimulus never reached both trap and commit paths");
		else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

/* mipsControl.f */
hw/ctrlPkg.sv
hw/instrDecoder.sv
hw/controlSequencer.sv
hw/datapathControl.sv
hw/controlUnit.sv
test/tbControlUnit.sv

/* run.sh */
#!/bin/sh
# Build and run the control unit testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module tbControlUnit -f mipsControl.f \
	&& ./obj_dir/VtbControlUnit > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0
